//--- source/axis_limit_pkg.sv
/*
 * shared definitions for the stream frame length limiter
 *   data, keep and length widths
 *   stream beat and frame status structs
 *   limiter state enum
 */
`default_nettype none

package axis_limit_pkg;

    // datapath is fixed at eight bytes per beat
    localparam int data_width = 64;
    localparam int keep_width = data_width / 8;

    // byte counters and reported frame lengths
    localparam int len_width = 16;

    // one stream beat
    // valid and ready are carried as separate wires next to it
    typedef struct packed {
        logic [data_width-1:0] data;
        // contiguous low-aligned byte enables
        logic [keep_width-1:0] keep;
        logic                  last;
        // error flag, set on a cut frame
        logic                  user;
    } axis_beat_t;

    // report for one finished output frame
    typedef struct packed {
        // bytes actually sent
        logic [len_width-1:0] length;
        logic                 truncated;
    } frame_status_t;

    // limiter FSM
    typedef enum logic [0:0] {
        // beats are forwarded
        st_pass    = 1'b0,
        // tail of an oversize frame is swallowed
        st_discard = 1'b1
    } limiter_state_t;

endpackage

`default_nettype wire

//--- source/axis_register.sv
/*
 * two-entry skid register for one stream link
 * registered ready, output stage plus temp stage
 */
`default_nettype none

module axis_register (
    input  logic                       clk,
    input  logic                       rst,

    // upstream side
    input  axis_limit_pkg::axis_beat_t s_beat,
    input  logic                       s_valid,
    output logic                       s_ready,

    // downstream side
    output axis_limit_pkg::axis_beat_t m_beat,
    output logic                       m_valid,
    input  logic                       m_ready
);

    // output stage
    axis_limit_pkg::axis_beat_t out_beat;
    logic                       out_valid;

    // temp stage, catches the one beat accepted while the output stalls
    axis_limit_pkg::axis_beat_t temp_beat;
    logic                       temp_valid;

    // registered upstream ready
    logic ready_reg;

    // beat movement this cycle
    logic in_to_out;
    logic in_to_temp;
    logic temp_to_out;

    // output free when it drains or holds nothing
    assign in_to_out   = ready_reg && (m_ready || !out_valid);
    assign in_to_temp  = ready_reg && m_ready == 1'b0 && out_valid;
    // input closed, so temp refills the output
    assign temp_to_out = !ready_reg && m_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg  <= 1'b0;
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            // open next cycle if output drains, both stages empty,
            // or temp empty and nothing arriving to fill it
            ready_reg <= m_ready
                || (!temp_valid && !out_valid)
                || (!temp_valid && !s_valid);

            if (in_to_out) begin
                out_valid <= s_valid;
            end else if (in_to_temp) begin
                temp_valid <= s_valid;
            end else if (temp_to_out) begin
                // temp empties into output
                out_valid  <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    // payload follows the same moves
    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_beat <= s_beat;
        end else if (in_to_temp) begin
            temp_beat <= s_beat;
        end else if (temp_to_out) begin
            out_beat <= temp_beat;
        end
    end

    assign s_ready = ready_reg;
    assign m_beat  = out_beat;
    assign m_valid = out_valid;

endmodule

`default_nettype wire

//--- source/axis_frame_limiter.sv
/*
 * frame length limiter
 * counts bytes per frame, cuts a frame on the beat that crosses MAX_BYTES,
 * swallows the rest of the input frame and reports each finished frame
 */
`default_nettype none

module axis_frame_limiter #(
    parameter int unsigned MAX_BYTES = 1500
) (
    input  logic                          clk,
    input  logic                          rst,

    input  axis_limit_pkg::axis_beat_t    in_beat,
    input  logic                          in_valid,
    output logic                          in_ready,

    output axis_limit_pkg::axis_beat_t    out_beat,
    output logic                          out_valid,
    input  logic                          out_ready,

    output logic                          frame_done,
    output axis_limit_pkg::frame_status_t frame_status
);

    localparam int keep_width = axis_limit_pkg::keep_width;
    localparam int len_width  = axis_limit_pkg::len_width;
    // bytes in one beat, 0 to keep_width
    localparam int cnt_width  = $clog2(keep_width + 1);
    // one spare bit so count plus beat cannot wrap
    localparam int sum_width  = len_width + 1;

    axis_limit_pkg::limiter_state_t state;
    // bytes already sent in the current frame
    logic [len_width-1:0] byte_cnt;

    logic [cnt_width-1:0]  in_bytes;
    logic [sum_width-1:0]  sum_bytes;
    logic [sum_width-1:0]  room;
    logic                  crossing;
    logic [keep_width-1:0] allow_mask;
    logic [cnt_width-1:0]  out_bytes;
    logic [len_width-1:0]  sent_bytes;
    logic                  in_xfer;
    logic                  out_xfer;

    // keep masks are contiguous, so counting ones gives the byte count
    function automatic logic [cnt_width-1:0] count_bytes(
        input logic [keep_width-1:0] keep
    );
        logic [cnt_width-1:0] n;
        n = '0;
        for (int i = 0; i < keep_width; i++) begin
            n = n + cnt_width'(keep[i]);
        end
        return n;
    endfunction

    // beat rewrite, purely combinational
    always_comb begin
        in_bytes  = count_bytes(in_beat.keep);
        sum_bytes = sum_width'(byte_cnt) + sum_width'(in_bytes);
        // bytes still allowed in this frame
        room      = sum_width'(MAX_BYTES) - sum_width'(byte_cnt);
        crossing  = sum_bytes > sum_width'(MAX_BYTES);

        // low bytes that still fit
        for (int i = 0; i < keep_width; i++) begin
            allow_mask[i] = sum_width'(i) < room;
        end

        out_beat = in_beat;
        if (crossing) begin
            // trim, end the frame and flag the error
            out_beat.keep = in_beat.keep & allow_mask;
            out_beat.last = 1'b1;
            out_beat.user = 1'b1;
        end

        out_bytes  = count_bytes(out_beat.keep);
        // equals MAX_BYTES on a crossing beat
        sent_bytes = byte_cnt + len_width'(out_bytes);
    end

    // handshake, pass-through or swallow
    always_comb begin
        if (state == axis_limit_pkg::st_pass) begin
            out_valid = in_valid;
            in_ready  = out_ready;
        end else begin
            out_valid = 1'b0;
            in_ready  = 1'b1;
        end
    end

    assign in_xfer  = in_valid && in_ready;
    assign out_xfer = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= axis_limit_pkg::st_pass;
            byte_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            // one pulse after each output last beat
            frame_done <= out_xfer && out_beat.last;

            case (state)
                axis_limit_pkg::st_pass: begin
                    if (out_xfer) begin
                        if (out_beat.last) begin
                            byte_cnt <= '0;
                            // cut before the input frame ended
                            if (!in_beat.last) begin
                                state <= axis_limit_pkg::st_discard;
                            end
                        end else begin
                            byte_cnt <= sent_bytes;
                        end
                    end
                end
                axis_limit_pkg::st_discard: begin
                    // drop beats up to and including input last
                    if (in_xfer && in_beat.last) begin
                        state <= axis_limit_pkg::st_pass;
                    end
                end
                default: state <= axis_limit_pkg::st_pass;
            endcase
        end
    end

    // report sampled with the last beat, valid while frame_done is high
    always_ff @(posedge clk) begin
        if (out_xfer && out_beat.last) begin
            frame_status.length    <= sent_bytes;
            frame_status.truncated <= crossing;
        end
    end

endmodule

`default_nettype wire

//--- source/axis_frame_stats.sv
/*
 * frame statistics
 * counts frames sent, frames truncated and bytes sent
 */
`default_nettype none

module axis_frame_stats (
    input  logic                          clk,
    input  logic                          rst,

    // one-cycle report from the limiter
    input  logic                          frame_done,
    input  axis_limit_pkg::frame_status_t frame_status,

    output logic [31:0]                   frame_count,
    output logic [31:0]                   trunc_count,
    output logic [31:0]                   byte_count
);

    logic [31:0] frame_count_reg;
    logic [31:0] trunc_count_reg;
    logic [31:0] byte_count_reg;

    // all three move together on each report
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_count_reg <= '0;
            trunc_count_reg <= '0;
            byte_count_reg  <= '0;
        end else if (frame_done) begin
            frame_count_reg <= frame_count_reg + 32'd1;
            // adds zero for a frame that passed intact
            trunc_count_reg <= trunc_count_reg + 32'(frame_status.truncated);
            // bytes actually sent, after any trim
            byte_count_reg  <= byte_count_reg + 32'(frame_status.length);
        end
    end

    // plain levels, wrap silently on overflow
    assign frame_count = frame_count_reg;
    assign trunc_count = trunc_count_reg;
    assign byte_count  = byte_count_reg;

endmodule

`default_nettype wire

//--- source/axis_limit_top.sv
/*
 * stream frame length limiter top level
 * input skid register, limiter, output skid register, statistics
 */
`default_nettype none

module axis_limit_top #(
    parameter int unsigned MAX_BYTES = 1500
) (
    input  logic                       clk,
    input  logic                       rst,

    // stream in
    input  axis_limit_pkg::axis_beat_t s_beat,
    input  logic                       s_valid,
    output logic                       s_ready,

    // stream out
    output axis_limit_pkg::axis_beat_t m_beat,
    output logic                       m_valid,
    input  logic                       m_ready,

    // statistics levels
    output logic [31:0]                frame_count,
    output logic [31:0]                trunc_count,
    output logic [31:0]                byte_count
);

    // input register to limiter
    axis_limit_pkg::axis_beat_t in_beat;
    logic                       in_valid;
    logic                       in_ready;

    // limiter to output register
    axis_limit_pkg::axis_beat_t lim_beat;
    logic                       lim_valid;
    logic                       lim_ready;

    // frame reports
    logic                          frame_done;
    axis_limit_pkg::frame_status_t frame_status;

    axis_register in_reg0 (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (in_beat),
        .m_valid (in_valid),
        .m_ready (in_ready)
    );

    // no latency, cuts and swallows oversize frames
    axis_frame_limiter #(
        .MAX_BYTES (MAX_BYTES)
    ) limiter0 (
        .clk          (clk),
        .rst          (rst),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_beat     (lim_beat),
        .out_valid    (lim_valid),
        .out_ready    (lim_ready),
        .frame_done   (frame_done),
        .frame_status (frame_status)
    );

    axis_register out_reg0 (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (lim_beat),
        .s_valid (lim_valid),
        .s_ready (lim_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    axis_frame_stats stats0 (
        .clk          (clk),
        .rst          (rst),
        .frame_done   (frame_done),
        .frame_status (frame_status),
        .frame_count  (frame_count),
        .trunc_count  (trunc_count),
        .byte_count   (byte_count)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
/*
 * testbench clock generator
 * free-running clock, period set by parameter
 */
`default_nettype none

module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);

    // starts low, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tests/axis_limit_tb.sv
/*
 * testbench for the stream frame length limiter
 * random frames from a fixed seed, reference model with expected beat queue
 * compare tasks for beats, counters and flags, reset checks
 */
`default_nettype none

module axis_limit_tb;

    localparam int max_bytes     = 40;
    localparam int num_frames    = 200;
    localparam int max_len       = 96;
    localparam int reset_cycles  = 16;
    localparam int beat_timeout  = 1000;
    localparam int drain_timeout = 20000;
    localparam int counter_lag   = 2;
    localparam int kw            = axis_limit_pkg::keep_width;

    logic                       clk;
    logic                       rst;
    axis_limit_pkg::axis_beat_t s_beat;
    logic                       s_valid;
    logic                       s_ready;
    axis_limit_pkg::axis_beat_t m_beat;
    logic                       m_valid;
    logic                       m_ready;
    logic [31:0]                frame_count;
    logic [31:0]                trunc_count;
    logic [31:0]                byte_count;

    integer seed;
    // separate stream for m_ready so the two processes never share draws
    integer ready_seed;

    // expected output beats, oldest first
    axis_limit_pkg::axis_beat_t exp_q[$];
    // frame under construction and its bytes per beat
    axis_limit_pkg::axis_beat_t frame_buf[0:15];
    int                         frame_bytes[0:15];
    int                         frame_beats;

    // expected statistics
    logic [31:0] exp_frames;
    logic [31:0] exp_trunc;
    logic [31:0] exp_bytes;

    // how many frames of each kind were sent
    int n_short;
    int n_cut_last;
    int n_cut_tail;
    int beats_seen;

    tb_clock #(
        .period (8)
    ) clock0 (
        .clk (clk)
    );

    axis_limit_top #(
        .MAX_BYTES (max_bytes)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .frame_count (frame_count),
        .trunc_count (trunc_count),
        .byte_count  (byte_count)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_beat(
        input axis_limit_pkg::axis_beat_t got,
        input axis_limit_pkg::axis_beat_t exp,
        input int                         index
    );
        string msg;
        if (got !== exp) begin
            msg = $sformatf("[FAIL] %0t: beat %0d got data=%h keep=%h last=%b user=%b",
                            $time, index, got.data, got.keep, got.last, got.user);
            msg = {msg, $sformatf(", exp data=%h keep=%h last=%b user=%b",
                                  exp.data, exp.keep, exp.last, exp.user)};
            report_error(msg);
        end
    endtask

    task automatic compare_count(input logic [31:0] got, input logic [31:0] exp,
                                 input string name);
        if (got !== exp) begin
            report_error($sformatf("[FAIL] %0t: %s got %0d expected %0d",
                                   $time, name, got, exp));
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_error($sformatf("[FAIL] %0t: %s got %b expected %b",
                                   $time, name, got, exp));
        end
    endtask

    // n low bytes enabled
    function automatic logic [kw-1:0] low_mask(input int n);
        logic [kw-1:0] m;
        m = '0;
        for (int i = 0; i < kw; i++) begin
            m[i] = i < n;
        end
        return m;
    endfunction

    // full beats, then one low-aligned partial beat if the length needs it
    task automatic build_frame(input int len);
        int nb;
        frame_beats = (len + kw - 1) / kw;
        for (int i = 0; i < frame_beats; i++) begin
            nb = len - i * kw;
            if (nb > kw) begin
                nb = kw;
            end
            frame_bytes[i]    = nb;
            frame_buf[i].data = {$random(seed), $random(seed)};
            frame_buf[i].keep = low_mask(nb);
            frame_buf[i].last = i == frame_beats - 1;
            frame_buf[i].user = ($random(seed) & 1) != 0;
        end
    endtask

    // limiter rule: cut on the beat whose bytes push the total past max_bytes
    task automatic model_frame(input int len);
        int                         sent;
        bit                         cut;
        axis_limit_pkg::axis_beat_t b;
        sent = 0;
        cut  = 1'b0;
        for (int i = 0; i < frame_beats && !cut; i++) begin
            b = frame_buf[i];
            if (sent + frame_bytes[i] > max_bytes) begin
                // only the bytes left before the limit survive, maybe none
                b.keep = low_mask(max_bytes - sent);
                b.last = 1'b1;
                b.user = 1'b1;
                cut    = 1'b1;
                if (i == frame_beats - 1) begin
                    n_cut_last++;
                end else begin
                    n_cut_tail++;
                end
            end else begin
                sent += frame_bytes[i];
            end
            exp_q.push_back(b);
        end
        exp_frames = exp_frames + 32'd1;
        if (cut) begin
            exp_trunc = exp_trunc + 32'd1;
            exp_bytes = exp_bytes + 32'(max_bytes);
        end else begin
            n_short++;
            exp_bytes = exp_bytes + 32'(len);
        end
    endtask

    // called just after a rising edge, returns just after the accepting edge
    task automatic send_beat(input axis_limit_pkg::axis_beat_t b);
        int  cycles;
        bit  accepted;
        cycles   = 0;
        accepted = 1'b0;
        s_beat   = b;
        s_valid  = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            if (s_ready) begin
                accepted = 1'b1;
            end else begin
                cycles++;
                if (cycles > beat_timeout) begin
                    report_error("timeout waiting for s_ready to accept an input beat");
                end
            end
            @(posedge clk);
            #1;
        end
        s_valid = 1'b0;
    endtask

    task automatic drive_frames();
        int len;
        int gap;
        for (int f = 0; f < num_frames; f++) begin
            len = 1 + $unsigned($random(seed)) % max_len;
            build_frame(len);
            model_frame(len);
            for (int i = 0; i < frame_beats; i++) begin
                // idle gap on s_valid about one beat in four
                if ($unsigned($random(seed)) % 4 == 0) begin
                    gap = 1 + $unsigned($random(seed)) % 3;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                end
                send_beat(frame_buf[i]);
            end
        end
    endtask

    // back-pressure, ready about two cycles in three
    task automatic drive_ready();
        forever begin
            @(posedge clk);
            #1;
            m_ready = ($unsigned($random(ready_seed)) % 3) != 0;
        end
    endtask

    // outputs are registered, so mid-cycle values show the coming transfer
    task automatic watch_output();
        axis_limit_pkg::axis_beat_t exp;
        forever begin
            @(negedge clk);
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("output beat appeared while no beat was expected");
                end else begin
                    exp = exp_q.pop_front();
                    compare_beat(m_beat, exp, beats_seen);
                    beats_seen++;
                end
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > drain_timeout) begin
                report_error("timeout waiting for the expected output beats to drain");
            end
        end
    endtask

    // counters trail the last output beat by two cycles
    task automatic wait_counter_lag();
        repeat (counter_lag) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        seed       = 45;
        ready_seed = $random(seed);
        rst        = 1'b1;
        s_valid    = 1'b0;
        s_beat     = '0;
        m_ready    = 1'b0;
        exp_frames = '0;
        exp_trunc  = '0;
        exp_bytes  = '0;
        n_short    = 0;
        n_cut_last = 0;
        n_cut_tail = 0;
        beats_seen = 0;

        // both sides closed while reset is held
        repeat (reset_cycles) begin
            @(posedge clk);
            #1;
            compare_flag(m_valid, 1'b0, "m_valid during reset");
            compare_flag(s_ready, 1'b0, "s_ready during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        compare_flag(m_valid, 1'b0, "m_valid in first cycle after reset");
        compare_flag(s_ready, 1'b0, "s_ready in first cycle after reset");

        fork
            drive_ready();
            watch_output();
        join_none

        @(posedge clk);
        #1;
        drive_frames();
        wait_drain();
        wait_counter_lag();

        // output idle once the last expected beat is out
        compare_flag(m_valid, 1'b0, "m_valid after the last frame");
        compare_count(frame_count, exp_frames, "frame_count");
        compare_count(trunc_count, exp_trunc, "trunc_count");
        compare_count(byte_count, exp_bytes, "byte_count");

        // random lengths must have hit all three frame kinds
        if (n_short == 0 || n_cut_last == 0 || n_cut_tail == 0) begin
            report_error("random frames missed a short, cut-at-last or cut-with-tail frame");
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- axis_limit.f
source/axis_limit_pkg.sv
source/axis_register.sv
source/axis_frame_limiter.sv
source/axis_frame_stats.sv
source/axis_limit_top.sv
tests/tb_clock.sv
tests/axis_limit_tb.sv
